// File: ctrl_pipe.f
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/pipe_skid.sv
hw/fetch_decode.sv
hw/mem_sequencer.sv
hw/writeback_stage.sv
hw/ctrl_pipe_top.sv
sim/tb_mem_model.sv
sim/ctrl_pipe_tb.sv

// File: hw/ctrl_pipe_cfg.svh
`ifndef CTRL_PIPE_CFG_SVH
`define CTRL_PIPE_CFG_SVH

// instruction, extension, address and data width
`define CP_WORD_W 16

// opcodes at or above this value are illegal
`define CP_LEGAL_OPCODES 46

// entries per inter-stage buffer
`define CP_SKID_DEPTH 2

`endif

// File: hw/ctrl_pipe_top.sv
`timescale 1ns/100ps
`include "ctrl_pipe_cfg.svh"

module ctrl_pipe_top
    import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    output logic                  instr_ready,
    input  logic [`CP_WORD_W-1:0] instr,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output mem_req_t              mem_req,
    input  logic                  mem_rsp_valid,
    input  logic [`CP_WORD_W-1:0] mem_rsp_data,
    output logic                  commit_valid,
    input  logic                  commit_ready,
    output commit_t               commit
);
    // fetch to first buffer
    logic     fd_valid;
    logic     fd_ready;
    dec_rec_t fd_rec;
    // first buffer to memory stage
    logic     ms_in_valid;
    logic     ms_in_ready;
    dec_rec_t ms_in_rec;
    // memory stage to second buffer
    logic     ms_out_valid;
    logic     ms_out_ready;
    dec_rec_t ms_out_rec;
    // second buffer to writeback
    logic     wb_in_valid;
    logic     wb_in_ready;
    dec_rec_t wb_in_rec;
    logic     load_wait;

    fetch_decode fetch_decode_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .rec_valid   (fd_valid),
        .rec_ready   (fd_ready),
        .rec         (fd_rec)
    );

    pipe_skid #(.payload_t(dec_rec_t)) skid_dec_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fd_valid),
        .in_ready  (fd_ready),
        .in_data   (fd_rec),
        .out_valid (ms_in_valid),
        .out_ready (ms_in_ready),
        .out_data  (ms_in_rec)
    );

    mem_sequencer mem_sequencer_i (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (ms_in_valid),
        .in_ready      (ms_in_ready),
        .in_rec        (ms_in_rec),
        .load_wait     (load_wait),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .out_valid     (ms_out_valid),
        .out_ready     (ms_out_ready),
        .out_rec       (ms_out_rec)
    );

    pipe_skid #(.payload_t(dec_rec_t)) skid_mem_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (ms_out_valid),
        .in_ready  (ms_out_ready),
        .in_data   (ms_out_rec),
        .out_valid (wb_in_valid),
        .out_ready (wb_in_ready),
        .out_data  (wb_in_rec)
    );

    writeback_stage writeback_stage_i (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (wb_in_valid),
        .in_ready      (wb_in_ready),
        .in_rec        (wb_in_rec),
        .load_wait     (load_wait),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .commit        (commit)
    );

endmodule

// File: hw/fetch_decode.sv
`timescale 1ns/100ps
`include "ctrl_pipe_cfg.svh"

module fetch_decode
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    output logic                  instr_ready,
    input  logic [`CP_WORD_W-1:0] instr,
    output logic                  rec_valid,
    input  logic                  rec_ready,
    output dec_rec_t              rec
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_EXT,
        S_PUSH
    } state_e;

    state_e                state;
    instr_t                instr_in;
    instr_t                instr_q;
    logic [`CP_WORD_W-1:0] ext_q;
    logic                  accept;
    logic                  illegal_q;
    logic                  ext_used_q;

    function automatic logic is_illegal(input opcode_t op);
        return op >= opcode_t'(`CP_LEGAL_OPCODES);
    endfunction

    // odd legal opcodes carry a second word
    function automatic logic needs_ext(input opcode_t op);
        return !is_illegal(op) && op[0];
    endfunction

    assign instr_in    = instr_t'(instr);
    assign instr_ready = (state != S_PUSH) && rec_ready;
    assign accept      = instr_valid && instr_ready;
    assign rec_valid   = state == S_PUSH;

    //////////////////////////////////////////////////////////////////////
    // fetch FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= S_IDLE;
        else
        begin
            case (state)
                S_IDLE:
                    if (accept)
                        state <= needs_ext(instr_in.opcode) ? S_EXT : S_PUSH;
                S_EXT:
                    if (accept)
                        state <= S_PUSH;
                S_PUSH:
                    if (rec_ready)
                        state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept && state == S_IDLE)
            instr_q <= instr_in;
        if (accept && state == S_EXT)
            ext_q <= instr;
    end

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    assign illegal_q  = is_illegal(instr_q.opcode);
    assign ext_used_q = needs_ext(instr_q.opcode);

    always_comb
    begin
        rec.alu_grp  = alu_grp_e'(instr_q.opcode[4:2]);
        rec.illegal  = illegal_q;
        rec.ext_used = ext_used_q;
        rec.ext_word = ext_used_q ? ext_q : '0;
        rec.rd       = instr_q.rd;
        rec.rs       = instr_q.rs;
        rec.mem_op   = MEM_NONE;
        rec.wb_op    = WB_NONE;
        // a load always writes back its data, and load write-back needs a load
        if (!illegal_q)
        begin
            if (instr_q.mem_op == MEM_LOAD)
            begin
                rec.mem_op = MEM_LOAD;
                rec.wb_op  = WB_LOAD;
            end
            else
            begin
                if (instr_q.mem_op == MEM_STORE)
                    rec.mem_op = MEM_STORE;
                if (instr_q.wb_op == WB_ALU)
                    rec.wb_op = WB_ALU;
            end
        end
    end

    // an illegal opcode takes one word and never asks for an extension
    a_illegal_one_word: assert property (@(posedge clk) disable iff (rst)
        ($rose(rec_valid) && rec.illegal)
        |-> (!rec.ext_used && rec.mem_op == MEM_NONE && $past(state) == S_IDLE));

endmodule

// File: hw/isa_pkg.sv
package isa_pkg;

    typedef logic [5:0] opcode_t;
    typedef logic [2:0] reg_idx_t;

    // opcode bits 4 down to 2
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SHF = 3'd5,
        ALU_CMP = 3'd6,
        ALU_MOV = 3'd7
    } alu_grp_e;

    // encoding 2'b11 is unused and decodes as none
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_ALU  = 2'd1,
        WB_LOAD = 2'd2
    } wb_op_e;

    // instruction word, msb first
    typedef struct packed {
        opcode_t  opcode;
        mem_op_e  mem_op;
        wb_op_e   wb_op;
        reg_idx_t rd;
        reg_idx_t rs;
    } instr_t;

endpackage

// File: hw/mem_sequencer.sv
`timescale 1ns/100ps
`include "ctrl_pipe_cfg.svh"

module mem_sequencer
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  dec_rec_t in_rec,
    input  logic     load_wait,
    output logic     mem_req_valid,
    input  logic     mem_req_ready,
    output mem_req_t mem_req,
    output logic     out_valid,
    input  logic     out_ready,
    output dec_rec_t out_rec
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_FWD
    } state_e;

    state_e   state;
    dec_rec_t rec_q;
    logic     load_pend;
    logic     is_store;
    logic     in_mem;
    logic     req_fire;

    assign in_ready  = state == S_IDLE;
    assign out_valid = state == S_FWD;
    assign out_rec   = rec_q;

    assign is_store = rec_q.mem_op == MEM_STORE;
    assign in_mem   = (in_rec.mem_op == MEM_LOAD) || (in_rec.mem_op == MEM_STORE);

    // loads wait until the previous load has been seen through writeback
    assign mem_req_valid = (state == S_REQ) && (is_store || !(load_pend || load_wait));
    assign req_fire      = mem_req_valid && mem_req_ready;

    assign mem_req.write = is_store;
    assign mem_req.addr  = rec_q.ext_used ? rec_q.ext_word : `CP_WORD_W'(rec_q.rs);

    //////////////////////////////////////////////////////////////////////
    // request FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= S_IDLE;
        else
        begin
            case (state)
                S_IDLE:
                    if (in_valid)
                        state <= in_mem ? S_REQ : S_FWD;
                S_REQ:
                    if (req_fire)
                        state <= S_FWD;
                S_FWD:
                    if (out_ready)
                        state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
            rec_q <= in_rec;
    end

    // load issued but not yet picked up by writeback
    always_ff @(posedge clk)
    begin
        if (rst)
            load_pend <= 1'b0;
        else if (req_fire && !is_store)
            load_pend <= 1'b1;
        else if (load_wait)
            load_pend <= 1'b0;
    end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)));

endmodule

// File: hw/pipe_pkg.sv
`include "ctrl_pipe_cfg.svh"

package pipe_pkg;
    import isa_pkg::*;

    // decoded instruction as it travels down the pipe
    typedef struct packed {
        alu_grp_e              alu_grp;
        logic                  illegal;
        logic                  ext_used;
        logic [`CP_WORD_W-1:0] ext_word;
        mem_op_e               mem_op;
        wb_op_e                wb_op;
        reg_idx_t              rd;
        reg_idx_t              rs;
    } dec_rec_t;

    // memory request port
    typedef struct packed {
        logic                  write;
        logic [`CP_WORD_W-1:0] addr;
    } mem_req_t;

    // one record per retired instruction
    typedef struct packed {
        reg_idx_t              rd;
        wb_op_e                wb_op;
        alu_grp_e              alu_grp;
        logic                  illegal;
        logic                  ext_used;
        logic [`CP_WORD_W-1:0] result;
    } commit_t;

endpackage

// File: hw/pipe_skid.sv
`timescale 1ns/100ps
`include "ctrl_pipe_cfg.svh"

module pipe_skid #(
    parameter type payload_t = logic
)(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    localparam int DEPTH = `CP_SKID_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // both flags come straight from the count, so no ready path crosses
    assign in_ready  = count < CNT_W'(DEPTH);
    assign out_valid = count != '0;
    assign out_data  = entries[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            entries[wr_ptr] <= in_data;
    end

    a_fill_bound: assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(DEPTH));

endmodule

// File: hw/writeback_stage.sv
`timescale 1ns/100ps
`include "ctrl_pipe_cfg.svh"

module writeback_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  dec_rec_t              in_rec,
    output logic                  load_wait,
    input  logic                  mem_rsp_valid,
    input  logic [`CP_WORD_W-1:0] mem_rsp_data,
    output logic                  commit_valid,
    input  logic                  commit_ready,
    output commit_t               commit
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_LWAIT,
        S_PRES
    } state_e;

    state_e                state;
    commit_t               commit_q;
    logic                  rsp_hold;
    logic [`CP_WORD_W-1:0] rsp_data_q;
    logic                  pop;
    logic                  rsp_here;

    assign in_ready     = state == S_IDLE;
    assign load_wait    = state == S_LWAIT;
    assign commit_valid = state == S_PRES;
    assign commit       = commit_q;
    assign pop          = in_valid && in_ready;
    assign rsp_here     = mem_rsp_valid || rsp_hold;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= S_IDLE;
        else
        begin
            case (state)
                S_IDLE:
                    if (pop)
                        state <= (in_rec.wb_op == WB_LOAD) ? S_LWAIT : S_PRES;
                S_LWAIT:
                    if (rsp_here)
                        state <= S_PRES;
                S_PRES:
                    if (commit_ready)
                        state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // response may beat its record here when commit is stalled
    always_ff @(posedge clk)
    begin
        if (rst)
            rsp_hold <= 1'b0;
        else if (state == S_LWAIT)
            rsp_hold <= 1'b0;
        else if (mem_rsp_valid)
            rsp_hold <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (mem_rsp_valid)
            rsp_data_q <= mem_rsp_data;
        if (pop)
        begin
            commit_q.rd       <= in_rec.rd;
            commit_q.wb_op    <= in_rec.wb_op;
            commit_q.alu_grp  <= in_rec.alu_grp;
            commit_q.illegal  <= in_rec.illegal;
            commit_q.ext_used <= in_rec.ext_used;
            // ext_word is already zero when unused
            commit_q.result   <= in_rec.ext_word;
        end
        else if (state == S_LWAIT && rsp_here)
            commit_q.result <= mem_rsp_valid ? mem_rsp_data : rsp_data_q;
    end

    // only one load in flight, so a held response is never overrun
    a_one_rsp: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |-> !rsp_hold);

endmodule

// File: sim/ctrl_pipe_tb.sv
`timescale 1ns/100ps
`include "ctrl_pipe_cfg.svh"

module ctrl_pipe_tb
    import isa_pkg::*, pipe_pkg::*;
();
    localparam int N_LS    = 40;
    localparam int N_BP    = 40;
    localparam int N_RAND  = 300;
    localparam int N_TOTAL = 64 + N_LS + N_BP + N_RAND;
    localparam int TIMEOUT = 40 * N_TOTAL + 200;

    typedef struct packed {
        commit_t  commit;
        logic     has_req;
        mem_req_t req;
    } expect_t;

    logic                  clk;
    logic                  rst;
    logic                  instr_valid;
    logic                  instr_ready;
    logic [`CP_WORD_W-1:0] instr;
    logic                  mem_req_valid;
    logic                  mem_req_ready;
    mem_req_t              mem_req;
    logic                  mem_rsp_valid;
    logic [`CP_WORD_W-1:0] mem_rsp_data;
    logic                  commit_valid;
    logic                  commit_ready;
    commit_t               commit;
    logic                  taken;
    mem_req_t              taken_req;
    int                    log_size;

    commit_t  exp_commits [$];
    mem_req_t exp_reqs [$];
    int       issued;
    int       committed;
    int       exp_req_total;
    int       req_total;
    int       val_errs;
    int       other_errs;
    int       cycles;
    logic     bp_on;
    int       bp_left;
    logic     held;
    commit_t  held_rec;

    initial
        clk = 1'b0;
    always #5 clk = ~clk;

    ctrl_pipe_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr_ready   (instr_ready),
        .instr         (instr),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .commit        (commit)
    );

    tb_mem_model mem_i (
        .clk           (clk),
        .rst           (rst),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .taken         (taken),
        .taken_req     (taken_req),
        .log_size      (log_size)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model and helpers
    //////////////////////////////////////////////////////////////////////

    function automatic expect_t ref_instr(input instr_t w, input logic [`CP_WORD_W-1:0] ext);
        expect_t               e;
        logic                  bad;
        logic                  use_ext;
        logic [`CP_WORD_W-1:0] addr;
        bad     = w.opcode >= opcode_t'(`CP_LEGAL_OPCODES);
        use_ext = !bad && w.opcode[0];
        addr    = use_ext ? ext : `CP_WORD_W'(w.rs);
        e.commit.rd       = w.rd;
        e.commit.alu_grp  = alu_grp_e'(w.opcode[4:2]);
        e.commit.illegal  = bad;
        e.commit.ext_used = use_ext;
        e.commit.wb_op    = WB_NONE;
        e.commit.result   = use_ext ? ext : '0;
        e.has_req         = 1'b0;
        e.req.write       = 1'b0;
        e.req.addr        = addr;
        if (!bad && w.mem_op == MEM_LOAD)
        begin
            e.has_req         = 1'b1;
            e.commit.wb_op    = WB_LOAD;
            e.commit.result   = addr ^ 16'hA5A5;
        end
        else if (!bad)
        begin
            e.has_req      = w.mem_op == MEM_STORE;
            e.req.write    = 1'b1;
            e.commit.wb_op = w.wb_op;
        end
        return e;
    endfunction

    // loads always write back, other ops pick none or alu
    function automatic instr_t rand_instr(input logic legal_only, input logic mem_only);
        instr_t w;
        int     sel;
        if (legal_only)
            w.opcode = opcode_t'($urandom % `CP_LEGAL_OPCODES);
        else
            w.opcode = opcode_t'($urandom % 64);
        sel      = mem_only ? 1 + $urandom % 2 : $urandom % 3;
        w.mem_op = mem_op_e'(sel[1:0]);
        if (w.mem_op == MEM_LOAD)
            w.wb_op = WB_LOAD;
        else
            w.wb_op = ($urandom % 2) ? WB_ALU : WB_NONE;
        w.rd = reg_idx_t'($urandom % 8);
        w.rs = reg_idx_t'($urandom % 8);
        return w;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            val_errs++;
        end
    endtask

    // word is taken on the rising edge after this returns
    task automatic send_word(input logic [`CP_WORD_W-1:0] w);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = w;
        while (!instr_ready)
            @(negedge clk);
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic send_instr(input instr_t w, input logic [`CP_WORD_W-1:0] ext);
        expect_t e;
        e = ref_instr(w, ext);
        send_word(w);
        if (e.commit.ext_used)
            send_word(ext);
        exp_commits.push_back(e.commit);
        if (e.has_req)
        begin
            exp_reqs.push_back(e.req);
            exp_req_total++;
        end
        issued++;
    endtask

    task automatic wait_drain();
        idle(1);
        while (committed < issued)
            @(posedge clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // commit side: back-pressure, hold check and compare
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        commit_t exp_c;
        if (rst)
        begin
            commit_ready = 1'b0;
            held         = 1'b0;
            bp_left      = 0;
        end
        else
        begin
            if (held && !commit_valid)
            begin
                $display("commit_valid dropped at %0t before the record was taken", $time);
                other_errs++;
            end
            else if (held)
                check_value("commit (held)", commit, held_rec);
            if (!bp_on)
                commit_ready = 1'b1;
            else if (bp_left == 0)
            begin
                commit_ready = $urandom % 2;
                bp_left      = 1 + $urandom % 8;
            end
            else
                bp_left--;
            held     = commit_valid && !commit_ready;
            held_rec = commit;
            if (commit_valid && commit_ready)
            begin
                if (exp_commits.size() == 0)
                begin
                    $display("a commit showed up at %0t with nothing outstanding", $time);
                    other_errs++;
                end
                else
                begin
                    exp_c = exp_commits.pop_front();
                    check_value("commit.rd", commit.rd, exp_c.rd);
                    check_value("commit.wb_op", commit.wb_op, exp_c.wb_op);
                    check_value("commit.alu_grp", commit.alu_grp, exp_c.alu_grp);
                    check_value("commit.illegal", commit.illegal, exp_c.illegal);
                    check_value("commit.ext_used", commit.ext_used, exp_c.ext_used);
                    check_value("commit.result", commit.result, exp_c.result);
                end
                committed++;
            end
        end
    end

    // memory model marks each taken request for one cycle
    always @(posedge clk)
    begin
        mem_req_t exp_r;
        if (!rst && taken)
        begin
            if (exp_reqs.size() == 0)
            begin
                $display("memory request at %0t that no instruction asked for", $time);
                other_errs++;
            end
            else
            begin
                exp_r = exp_reqs.pop_front();
                check_value("mem_req.write", taken_req.write, exp_r.write);
                check_value("mem_req.addr", taken_req.addr, exp_r.addr);
            end
            req_total++;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT)
        begin
            $display("run timed out after %0d cycles, %0d of %0d instructions committed",
                     cycles, committed, issued);
            $display("Test failures found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        instr_t w;
        int     op;
        void'($urandom(82214));
        rst           = 1'b1;
        instr_valid   = 1'b0;
        instr         = '0;
        commit_ready  = 1'b0;
        bp_on         = 1'b0;
        issued        = 0;
        committed     = 0;
        exp_req_total = 0;
        req_total     = 0;
        val_errs      = 0;
        other_errs    = 0;
        cycles        = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // every legal opcode, no memory access
        for (op = 0; op < `CP_LEGAL_OPCODES; op++)
        begin
            w        = rand_instr(1'b1, 1'b0);
            w.opcode = opcode_t'(op);
            w.mem_op = MEM_NONE;
            w.wb_op  = WB_ALU;
            send_instr(w, `CP_WORD_W'($urandom));
        end
        wait_drain();

        // illegal opcodes with random memory fields
        for (op = `CP_LEGAL_OPCODES; op < 64; op++)
        begin
            w        = rand_instr(1'b0, 1'b0);
            w.opcode = opcode_t'(op);
            send_instr(w, `CP_WORD_W'($urandom));
        end
        wait_drain();

        repeat (N_LS)
            send_instr(rand_instr(1'b1, 1'b1), `CP_WORD_W'($urandom));
        wait_drain();

        bp_on = 1'b1;
        repeat (N_BP)
            send_instr(rand_instr(1'b0, 1'b0), `CP_WORD_W'($urandom));
        wait_drain();
        bp_on = 1'b0;

        repeat (N_RAND)
        begin
            idle($urandom % 4);
            send_instr(rand_instr(1'b0, 1'b0), `CP_WORD_W'($urandom));
        end
        wait_drain();
        repeat (10) @(posedge clk);

        check_value("commit count", committed, issued);
        check_value("mem request count", log_size, exp_req_total);
        if (exp_reqs.size() != 0)
        begin
            $display("%0d expected memory requests never reached memory", exp_reqs.size());
            other_errs++;
        end
        $display("done: %0d value errors, %0d other errors, %0d instructions, %0d requests",
                 val_errs, other_errs, issued, req_total);
        if (val_errs + other_errs == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: sim/tb_mem_model.sv
`timescale 1ns/100ps
`include "ctrl_pipe_cfg.svh"

module tb_mem_model
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_req_valid,
    output logic                  mem_req_ready,
    input  mem_req_t              mem_req,
    output logic                  mem_rsp_valid,
    output logic [`CP_WORD_W-1:0] mem_rsp_data,
    output logic                  taken,
    output mem_req_t              taken_req,
    output int                    log_size
);
    mem_req_t              req_log [$];
    int                    accept_dly;
    logic                  dly_armed;
    int                    rsp_dly;
    logic                  rsp_busy;
    logic [`CP_WORD_W-1:0] rsp_word;

    initial
    begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        taken         = 1'b0;
        taken_req     = '0;
        log_size      = 0;
        dly_armed     = 1'b0;
        rsp_busy      = 1'b0;
    end

    // everything moves on the falling edge
    always @(negedge clk)
    begin
        mem_rsp_valid = 1'b0;
        mem_req_ready = 1'b0;
        taken         = 1'b0;
        if (rst)
        begin
            dly_armed = 1'b0;
            rsp_busy  = 1'b0;
        end
        else
        begin
            // one-cycle pulse, 1 to 4 cycles after the load was taken
            if (rsp_busy)
            begin
                rsp_dly = rsp_dly - 1;
                if (rsp_dly == 0)
                begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data  = rsp_word;
                    rsp_busy      = 1'b0;
                end
            end
            if (mem_req_valid)
            begin
                if (!dly_armed)
                begin
                    accept_dly = $urandom % 4;
                    dly_armed  = 1'b1;
                end
                if (accept_dly == 0)
                begin
                    // taken on the coming rising edge
                    mem_req_ready = 1'b1;
                    taken         = 1'b1;
                    taken_req     = mem_req;
                    dly_armed     = 1'b0;
                    req_log.push_back(mem_req);
                    log_size = req_log.size();
                    if (!mem_req.write)
                    begin
                        rsp_busy = 1'b1;
                        rsp_dly  = 1 + $urandom % 4;
                        rsp_word = mem_req.addr ^ 16'hA5A5;
                    end
                end
                else
                    accept_dly = accept_dly - 1;
            end
        end
    end

endmodule
